/* design/llc_pkg.sv */
`default_nettype none

package llc_pkg;

    localparam int LLC_WAYS     = 4;
    localparam int LLC_WAY_BITS = 2;
    localparam int LLC_SETS     = 16;
    localparam int LLC_SET_BITS = 4;
    localparam int LLC_TAG_BITS = 8;
    localparam int ADDR_BITS    = LLC_TAG_BITS + LLC_SET_BITS;
    localparam int DMA_LEN_BITS = 4;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;

    // tag sits in the upper bits.
    typedef logic [ADDR_BITS-1:0] line_addr_t;

    // beats minus one.
    typedef logic [DMA_LEN_BITS-1:0] dma_len_t;

    typedef enum logic [2:0] {
        REQ_READ      = 3'd0,
        REQ_WRITE     = 3'd1,
        REQ_DMA_READ  = 3'd2,
        REQ_DMA_WRITE = 3'd3,
        REQ_FLUSH     = 3'd4
    } req_kind_t;

endpackage

`default_nettype wire

/* design/llc_input_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_input_decoder
    import llc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  req_valid,
    input  req_kind_t  req_kind,
    input  line_addr_t req_addr,
    input  dma_len_t   req_len,
    input  wire logic  busy,
    output logic       decode_en,
    output req_kind_t  req_kind_q,
    output llc_set_t   req_set,
    output llc_tag_t   req_tag,
    output line_addr_t req_addr_q,
    output dma_len_t   req_len_q,
    output logic       set_req_stall,
    output logic       set_flush_stall,
    output logic       update_dma_addr_from_req
);

    logic accept;
    logic is_dma;

    assign accept = req_valid && !busy; // strobes while busy are dropped.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            decode_en <= 1'b0;
        end else begin
            decode_en <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_kind_q <= req_kind;
            req_addr_q <= req_addr;
            req_len_q  <= req_len;
        end
    end

    assign req_set = req_addr_q[LLC_SET_BITS-1:0];
    assign req_tag = req_addr_q[ADDR_BITS-1:LLC_SET_BITS];

    assign is_dma = (req_kind_q == REQ_DMA_READ) || (req_kind_q == REQ_DMA_WRITE);

    assign set_flush_stall          = decode_en && (req_kind_q == REQ_FLUSH);
    assign set_req_stall            = decode_en && (req_kind_q != REQ_FLUSH);
    assign update_dma_addr_from_req = decode_en && is_dma;

endmodule

`default_nettype wire

/* design/llc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_regs
    import llc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  decode_en,
    input  wire logic  update_dma_addr_from_req,
    input  line_addr_t req_addr_q,
    input  dma_len_t   req_len_q,
    input  wire logic  set_req_stall,
    input  wire logic  clr_req_stall,
    input  wire logic  set_flush_stall,
    input  wire logic  clr_flush_stall,
    input  wire logic  clr_rst_stall,
    input  wire logic  incr_rst_flush_set,
    input  wire logic  clr_rst_flush_set,
    input  wire logic  incr_dma_addr,
    input  wire logic  set_recall_pending,
    input  wire logic  clr_recall_pending,
    input  wire logic  set_dma_pending,
    input  wire logic  clr_dma_pending,
    input  wire logic  lookup_en,
    input  llc_tag_t   victim_tag,
    input  llc_set_t   rd_set,
    output logic       busy,
    output logic       rst_stall,
    output logic       flush_stall,
    output logic       req_stall,
    output llc_set_t   rst_flush_set,
    output line_addr_t dma_addr,
    output dma_len_t   dma_remaining,
    output logic       recall_pending,
    output logic       dma_pending,
    output line_addr_t addr_evict
);

    // held until the reset walk finishes.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (clr_rst_stall) begin
            rst_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_stall <= 1'b0;
        end else if (clr_flush_stall) begin
            flush_stall <= 1'b0;
        end else if (set_flush_stall) begin
            flush_stall <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
        end else if (clr_req_stall) begin
            req_stall <= 1'b0;
        end else if (set_req_stall) begin
            req_stall <= 1'b1;
        end
    end

    // shared by reset and flush walks.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_flush_set <= '0;
        end else if (clr_rst_flush_set) begin
            rst_flush_set <= '0;
        end else if (incr_rst_flush_set) begin
            rst_flush_set <= rst_flush_set + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_addr      <= '0;
            dma_remaining <= '0;
        end else if (update_dma_addr_from_req) begin
            dma_addr      <= req_addr_q;
            dma_remaining <= req_len_q;
        end else if (incr_dma_addr) begin
            dma_addr      <= dma_addr + 1'b1;
            dma_remaining <= dma_remaining - 1'b1; // wraps after the last beat.
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            recall_pending <= 1'b0;
        end else if (clr_recall_pending) begin
            recall_pending <= 1'b0;
        end else if (set_recall_pending) begin
            recall_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_pending <= 1'b0;
        end else if (clr_dma_pending) begin
            dma_pending <= 1'b0;
        end else if (set_dma_pending) begin
            dma_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_evict <= '0;
        end else if (lookup_en) begin
            addr_evict <= {victim_tag, rd_set};
        end
    end

    // decode_en covers the cycle before the stall flag lands.
    assign busy = rst_stall || flush_stall || req_stall || decode_en;

endmodule

`default_nettype wire

/* design/llc_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_tag_store
    import llc_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  llc_set_t  rd_set,
    input  llc_tag_t  lookup_tag,
    input  wire logic scan_dirty,
    input  wire logic wr_en,
    input  llc_way_t  wr_way,
    input  llc_tag_t  wr_tag,
    input  wire logic wr_valid,
    input  wire logic wr_dirty,
    input  wire logic clr_set_en,
    input  wire logic adv_ptr,
    output logic      hit,
    output llc_way_t  hit_way,
    output logic      hit_dirty,
    output llc_way_t  way_next,
    output logic      victim_valid,
    output logic      victim_dirty,
    output llc_tag_t  victim_tag
);

    llc_tag_t            tags  [LLC_SETS][LLC_WAYS];
    logic [LLC_WAYS-1:0] valid [LLC_SETS];
    logic [LLC_WAYS-1:0] dirty [LLC_SETS];
    llc_way_t            ptr   [LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[rd_set][wr_way] <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (clr_set_en) begin
            valid[rd_set] <= '0;
            dirty[rd_set] <= '0;
            ptr[rd_set]   <= '0;
        end else begin
            if (wr_en) begin
                valid[rd_set][wr_way] <= wr_valid;
                dirty[rd_set][wr_way] <= wr_dirty;
            end
            if (adv_ptr) begin
                ptr[rd_set] <= ptr[rd_set] + 1'b1;
            end
        end
    end

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        way_next = ptr[rd_set];
        // downward loops leave the lowest match.
        for (int w = LLC_WAYS - 1; w >= 0; w--) begin
            if (valid[rd_set][w] && tags[rd_set][w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
        end
        if (scan_dirty) begin
            // flush looks for the lowest dirty line instead.
            for (int w = LLC_WAYS - 1; w >= 0; w--) begin
                if (valid[rd_set][w] && dirty[rd_set][w]) begin
                    way_next = llc_way_t'(w);
                end
            end
        end else begin
            for (int w = LLC_WAYS - 1; w >= 0; w--) begin
                if (!valid[rd_set][w]) begin
                    way_next = llc_way_t'(w);
                end
            end
        end
    end

    assign hit_dirty    = dirty[rd_set][hit_way];
    assign victim_valid = valid[rd_set][way_next];
    assign victim_dirty = victim_valid && dirty[rd_set][way_next];
    assign victim_tag   = tags[rd_set][way_next];

endmodule

`default_nettype wire

/* design/llc_process.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_process
    import llc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  decode_en,
    input  req_kind_t  req_kind_q,
    input  llc_set_t   req_set,
    input  llc_tag_t   req_tag,
    input  wire logic  rst_stall,
    input  wire logic  flush_stall,
    input  wire logic  req_stall,
    input  llc_set_t   rst_flush_set,
    input  line_addr_t dma_addr,
    input  dma_len_t   dma_remaining,
    input  wire logic  recall_pending,
    input  wire logic  dma_pending,
    input  line_addr_t addr_evict,
    input  wire logic  hit,
    input  llc_way_t   hit_way,
    input  wire logic  hit_dirty,
    input  llc_way_t   way_next,
    input  wire logic  victim_valid,
    input  wire logic  victim_dirty,
    input  llc_tag_t   victim_tag,
    output logic       clr_rst_stall,
    output logic       clr_req_stall,
    output logic       clr_flush_stall,
    output logic       incr_rst_flush_set,
    output logic       clr_rst_flush_set,
    output logic       incr_dma_addr,
    output logic       set_recall_pending,
    output logic       clr_recall_pending,
    output logic       set_dma_pending,
    output logic       clr_dma_pending,
    output logic       lookup_en,
    output llc_set_t   rd_set,
    output llc_tag_t   lookup_tag,
    output logic       scan_dirty,
    output logic       wr_en,
    output llc_way_t   wr_way,
    output llc_tag_t   wr_tag,
    output logic       wr_valid,
    output logic       wr_dirty,
    output logic       clr_set_en,
    output logic       adv_ptr,
    output logic       resp_valid,
    output logic       resp_hit,
    output llc_way_t   resp_way,
    output logic       evict_valid,
    output line_addr_t evict_addr,
    output logic       dma_valid,
    output line_addr_t dma_addr_out,
    output logic       dma_hit,
    output logic       flush_done
);

    typedef enum logic [3:0] {
        ST_RST_WALK, ST_IDLE, ST_LOOKUP, ST_EVICT, ST_RESPOND,
        ST_DMA_BEAT, ST_DMA_RECALL, ST_FLUSH_SCAN, ST_FLUSH_EVICT
    } state_t;

    state_t     state;
    state_t     state_next;
    logic       hit_q;
    llc_way_t   way_q;
    line_addr_t cur_addr;
    logic       is_write;
    logic       last_set;
    logic       walking;

    assign cur_addr = dma_pending ? dma_addr : {req_tag, req_set};
    assign is_write = (req_kind_q == REQ_WRITE);
    assign last_set = (rst_flush_set == llc_set_t'(LLC_SETS - 1));
    assign walking  = (state == ST_RST_WALK) || scan_dirty;

    assign rd_set     = walking ? rst_flush_set : cur_addr[LLC_SET_BITS-1:0];
    assign lookup_tag = cur_addr[ADDR_BITS-1:LLC_SET_BITS];
    assign scan_dirty = (state == ST_FLUSH_SCAN) || (state == ST_FLUSH_EVICT);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_RST_WALK;
        end else begin
            state <= state_next;
        end
    end

    // lookup result held for the later report.
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            hit_q <= hit;
            way_q <= hit ? hit_way : way_next;
        end
    end

    always_comb begin
        state_next         = state;
        clr_rst_stall      = 1'b0;
        clr_req_stall      = 1'b0;
        clr_flush_stall    = 1'b0;
        incr_rst_flush_set = 1'b0;
        clr_rst_flush_set  = 1'b0;
        incr_dma_addr      = 1'b0;
        set_recall_pending = 1'b0;
        clr_recall_pending = 1'b0;
        set_dma_pending    = 1'b0;
        clr_dma_pending    = 1'b0;
        lookup_en          = 1'b0;
        wr_en              = 1'b0;
        wr_way             = hit_way;
        wr_tag             = lookup_tag;
        wr_valid           = 1'b1;
        wr_dirty           = 1'b0;
        clr_set_en         = 1'b0;
        adv_ptr            = 1'b0;
        resp_valid         = 1'b0;
        evict_valid        = 1'b0;
        dma_valid          = 1'b0;
        flush_done         = 1'b0;
        case (state)
            ST_RST_WALK: begin
                if (rst_stall) begin
                    clr_set_en         = 1'b1; // one set per cycle.
                    incr_rst_flush_set = 1'b1;
                    if (last_set) begin
                        clr_rst_stall     = 1'b1;
                        clr_rst_flush_set = 1'b1;
                        state_next        = ST_IDLE;
                    end
                end else begin
                    state_next = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (decode_en) begin
                    if (req_kind_q == REQ_FLUSH) begin
                        state_next = ST_FLUSH_SCAN;
                    end else begin
                        set_dma_pending = (req_kind_q == REQ_DMA_READ) ||
                                          (req_kind_q == REQ_DMA_WRITE);
                        state_next      = ST_LOOKUP;
                    end
                end
            end
            ST_LOOKUP: begin
                lookup_en = 1'b1;
                if (dma_pending) begin
                    // read recall cleans the line and write invalidates it.
                    wr_en    = hit;
                    wr_valid = (req_kind_q == REQ_DMA_READ);
                    if (hit && hit_dirty) begin
                        set_recall_pending = 1'b1;
                        state_next         = ST_DMA_RECALL;
                    end else begin
                        state_next = ST_DMA_BEAT;
                    end
                end else if (hit) begin
                    wr_en      = 1'b1;
                    wr_dirty   = hit_dirty || is_write;
                    state_next = ST_RESPOND;
                end else begin
                    wr_en      = 1'b1;
                    wr_way     = way_next;
                    wr_dirty   = is_write;
                    adv_ptr    = victim_valid; // only when the set is full.
                    state_next = victim_dirty ? ST_EVICT : ST_RESPOND;
                end
            end
            ST_EVICT: begin
                evict_valid = 1'b1;
                state_next  = ST_RESPOND;
            end
            ST_RESPOND: begin
                resp_valid    = 1'b1;
                clr_req_stall = req_stall;
                state_next    = ST_IDLE;
            end
            ST_DMA_RECALL: begin
                evict_valid        = 1'b1;
                clr_recall_pending = 1'b1;
                state_next         = ST_DMA_BEAT;
            end
            ST_DMA_BEAT: begin
                dma_valid     = 1'b1;
                incr_dma_addr = 1'b1;
                if (dma_remaining == '0) begin
                    clr_dma_pending = 1'b1;
                    clr_req_stall   = req_stall;
                    state_next      = ST_IDLE;
                end else begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_FLUSH_SCAN, ST_FLUSH_EVICT: begin
                // an evict cycle reports the previous line and keeps scanning.
                evict_valid = (state == ST_FLUSH_EVICT);
                lookup_en   = 1'b1;
                if (victim_dirty) begin
                    wr_en      = 1'b1;
                    wr_way     = way_next;
                    wr_tag     = victim_tag;
                    wr_valid   = 1'b0;
                    state_next = ST_FLUSH_EVICT;
                end else begin
                    clr_set_en         = 1'b1;
                    incr_rst_flush_set = 1'b1;
                    state_next         = ST_FLUSH_SCAN;
                    if (last_set) begin
                        flush_done        = flush_stall;
                        clr_flush_stall   = 1'b1;
                        clr_rst_flush_set = 1'b1;
                        state_next        = ST_IDLE;
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign resp_hit     = hit_q;
    assign resp_way     = way_q;
    assign dma_hit      = hit_q;
    assign dma_addr_out = dma_addr;
    assign evict_addr   = recall_pending ? dma_addr : addr_evict;

endmodule

`default_nettype wire

/* design/llc_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_ctrl_top
    import llc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  req_valid,
    input  req_kind_t  req_kind,
    input  line_addr_t req_addr,
    input  dma_len_t   req_len,
    output logic       busy,
    output logic       resp_valid,
    output logic       resp_hit,
    output llc_way_t   resp_way,
    output logic       evict_valid,
    output line_addr_t evict_addr,
    output logic       dma_valid,
    output line_addr_t dma_addr,
    output logic       dma_hit,
    output logic       flush_done
);

    logic       decode_en, set_req_stall, set_flush_stall, update_dma_addr_from_req;
    req_kind_t  req_kind_q;
    llc_set_t   req_set, rst_flush_set, rd_set;
    llc_tag_t   req_tag, lookup_tag, wr_tag, victim_tag;
    line_addr_t req_addr_q, dma_cur_addr, addr_evict;
    dma_len_t   req_len_q, dma_remaining;
    logic       clr_rst_stall, clr_req_stall, clr_flush_stall;
    logic       incr_rst_flush_set, clr_rst_flush_set, incr_dma_addr;
    logic       set_recall_pending, clr_recall_pending, set_dma_pending, clr_dma_pending;
    logic       lookup_en, rst_stall, flush_stall, req_stall, recall_pending, dma_pending;
    logic       scan_dirty, wr_en, wr_valid, wr_dirty, clr_set_en, adv_ptr;
    logic       hit, hit_dirty, victim_valid, victim_dirty;
    llc_way_t   wr_way, hit_way, way_next;

    llc_input_decoder u_decoder (.*);

    llc_regs u_regs (
        .*,
        .dma_addr (dma_cur_addr)
    );

    llc_process u_process (
        .*,
        .dma_addr     (dma_cur_addr),
        .dma_addr_out (dma_addr)
    );

    llc_tag_store u_tag_store (.*);

endmodule

`default_nettype wire

/* testbench/llc_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_ctrl_tb
    import llc_pkg::*;
();

    localparam int TIMEOUT  = 200;
    localparam int EV_EVICT = 0;
    localparam int EV_DMA   = 1;
    localparam int EV_RESP  = 2;
    localparam int EV_FLUSH = 3;
    localparam int NO_EXP   = 2; // no fixed hit expectation.

    logic       clk;
    logic       rst;
    logic       req_valid;
    req_kind_t  req_kind;
    line_addr_t req_addr;
    dma_len_t   req_len;
    logic       busy;
    logic       resp_valid;
    logic       resp_hit;
    llc_way_t   resp_way;
    logic       evict_valid;
    line_addr_t evict_addr;
    logic       dma_valid;
    line_addr_t dma_addr;
    logic       dma_hit;
    logic       flush_done;

    // stimulus table with one request per row.
    req_kind_t  tbl_kind [$];
    line_addr_t tbl_addr [$];
    dma_len_t   tbl_len  [$];
    int         tbl_exp  [$];

    // reference tag model.
    llc_tag_t m_tag   [LLC_SETS][LLC_WAYS];
    logic     m_valid [LLC_SETS][LLC_WAYS];
    logic     m_dirty [LLC_SETS][LLC_WAYS];
    llc_way_t m_ptr   [LLC_SETS];

    int         exp_kind [$];
    line_addr_t exp_addr [$];
    logic       exp_hit  [$];
    llc_way_t   exp_way  [$];
    int         obs_kind [$];
    line_addr_t obs_addr [$];
    logic       obs_hit  [$];
    llc_way_t   obs_way  [$];

    int err_count;
    int pass_count;
    int fail_count;
    bit timed_out;

    llc_ctrl_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void add_entry(input req_kind_t kind, input line_addr_t addr,
                                      input dma_len_t len, input int exp);
        tbl_kind.push_back(kind);
        tbl_addr.push_back(addr);
        tbl_len.push_back(len);
        tbl_exp.push_back(exp);
    endfunction

    function automatic void push_exp(input int kind, input line_addr_t addr,
                                     input logic hit, input llc_way_t way);
        exp_kind.push_back(kind);
        exp_addr.push_back(addr);
        exp_hit.push_back(hit);
        exp_way.push_back(way);
    endfunction

    function automatic void push_obs(input int kind, input line_addr_t addr,
                                     input logic hit, input llc_way_t way);
        obs_kind.push_back(kind);
        obs_addr.push_back(addr);
        obs_hit.push_back(hit);
        obs_way.push_back(way);
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < LLC_SETS; s++) begin
            m_ptr[s] = '0;
            for (int w = 0; w < LLC_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endfunction

    function automatic void model_find(input llc_set_t s, input llc_tag_t t,
                                       output logic hit, output llc_way_t way);
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (!hit && m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = llc_way_t'(w);
            end
        end
    endfunction

    function automatic logic predict_cpu(input req_kind_t kind, input line_addr_t addr);
        llc_set_t s;
        llc_tag_t t;
        logic     hit;
        logic     found;
        llc_way_t way;
        s = addr[LLC_SET_BITS-1:0];
        t = addr[ADDR_BITS-1:LLC_SET_BITS];
        model_find(s, t, hit, way);
        if (hit) begin
            m_dirty[s][way] = m_dirty[s][way] || (kind == REQ_WRITE);
        end else begin
            found = 1'b0;
            for (int w = 0; w < LLC_WAYS; w++) begin
                if (!found && !m_valid[s][w]) begin
                    found = 1'b1;
                    way   = llc_way_t'(w);
                end
            end
            if (!found) begin
                way      = m_ptr[s]; // full set goes round robin.
                m_ptr[s] = m_ptr[s] + 1'b1;
                if (m_dirty[s][way]) begin
                    push_exp(EV_EVICT, {m_tag[s][way], s}, 1'b0, '0);
                end
            end
            m_tag[s][way]   = t;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = (kind == REQ_WRITE);
        end
        push_exp(EV_RESP, addr, hit, way);
        return hit;
    endfunction

    function automatic void predict_dma(input req_kind_t kind, input line_addr_t addr,
                                        input dma_len_t len);
        line_addr_t a;
        llc_set_t   s;
        logic       hit;
        llc_way_t   way;
        for (int i = 0; i <= int'(len); i++) begin
            a = addr + line_addr_t'(i);
            s = a[LLC_SET_BITS-1:0];
            model_find(s, a[ADDR_BITS-1:LLC_SET_BITS], hit, way);
            if (hit) begin
                if (m_dirty[s][way]) begin
                    push_exp(EV_EVICT, a, 1'b0, '0); // recall first.
                end
                m_dirty[s][way] = 1'b0;
                if (kind == REQ_DMA_WRITE) begin
                    m_valid[s][way] = 1'b0;
                end
            end
            push_exp(EV_DMA, a, hit, '0);
        end
    endfunction

    function automatic void predict_flush();
        for (int s = 0; s < LLC_SETS; s++) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                if (m_valid[s][w] && m_dirty[s][w]) begin
                    push_exp(EV_EVICT, {m_tag[s][w], llc_set_t'(s)}, 1'b0, '0);
                end
            end
        end
        model_clear();
        push_exp(EV_FLUSH, '0, 1'b0, '0);
    endfunction

    function automatic void sample_outputs();
        if (evict_valid) push_obs(EV_EVICT, evict_addr, 1'b0, '0);
        if (dma_valid)   push_obs(EV_DMA, dma_addr, dma_hit, '0);
        if (resp_valid)  push_obs(EV_RESP, '0, resp_hit, resp_way);
        if (flush_done)  push_obs(EV_FLUSH, '0, 1'b0, '0);
    endfunction

    task automatic check_resp(input logic exp_h, input llc_way_t exp_w,
                              input logic got_h, input llc_way_t got_w);
        if (got_h !== exp_h) begin
            $display("** Error resp_hit: expected %h, got %h", exp_h, got_h);
            err_count++;
        end
        if (got_w !== exp_w) begin
            $display("** Error resp_way: expected %h, got %h", exp_w, got_w);
            err_count++;
        end
    endtask

    task automatic check_evict(input line_addr_t exp_a, input line_addr_t got_a);
        if (got_a !== exp_a) begin
            $display("** Error evict_addr: expected %h, got %h", exp_a, got_a);
            err_count++;
        end
    endtask

    task automatic check_dma(input line_addr_t exp_a, input logic exp_h,
                             input line_addr_t got_a, input logic got_h);
        if (got_a !== exp_a) begin
            $display("** Error dma_addr: expected %h, got %h", exp_a, got_a);
            err_count++;
        end
        if (got_h !== exp_h) begin
            $display("** Error dma_hit: expected %h, got %h", exp_h, got_h);
            err_count++;
        end
    endtask

    task automatic send_request(input req_kind_t kind, input line_addr_t addr,
                                input dma_len_t len);
        @(posedge clk);
        req_valid <= 1'b1;
        req_kind  <= kind;
        req_addr  <= addr;
        req_len   <= len;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic collect_results(output bit ok);
        int cycles;
        cycles = 0;
        while (obs_kind.size() < exp_kind.size() && cycles < TIMEOUT) begin
            @(negedge clk);
            sample_outputs();
            cycles++;
        end
        ok = (obs_kind.size() >= exp_kind.size());
        if (!ok) begin
            $display("timeout: %0d of %0d results arrived", obs_kind.size(), exp_kind.size());
        end
    endtask

    // any strobe here belongs to no request.
    task automatic wait_idle(output bit ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cycles < TIMEOUT && (busy || cycles == 0)) begin
            if (resp_valid || evict_valid || dma_valid || flush_done) begin
                $display("unexpected result strobe while waiting for busy to fall");
                err_count++;
            end
            if (busy) begin
                @(negedge clk);
            end
            cycles++;
        end
        ok = !busy;
        if (!ok) begin
            $display("timeout: busy still high after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic compare_results();
        for (int i = 0; i < exp_kind.size(); i++) begin
            if (obs_kind[i] != exp_kind[i]) begin
                $display("result %0d is of the wrong kind, %0d instead of %0d",
                         i, obs_kind[i], exp_kind[i]);
                err_count++;
            end else if (exp_kind[i] == EV_EVICT) begin
                check_evict(exp_addr[i], obs_addr[i]);
            end else if (exp_kind[i] == EV_DMA) begin
                check_dma(exp_addr[i], exp_hit[i], obs_addr[i], obs_hit[i]);
            end else if (exp_kind[i] == EV_RESP) begin
                check_resp(exp_hit[i], exp_way[i], obs_hit[i], obs_way[i]);
            end
        end
    endtask

    function automatic void build_table();
        add_entry(REQ_READ, 12'h123, '0, 0);
        add_entry(REQ_READ, 12'h123, '0, 1);
        add_entry(REQ_READ, 12'h225, '0, 0);
        add_entry(REQ_READ, 12'h235, '0, 0);
        add_entry(REQ_READ, 12'h245, '0, 0);
        add_entry(REQ_READ, 12'h255, '0, 0);
        add_entry(REQ_READ, 12'h265, '0, 0); // fifth tag in set 5.
        add_entry(REQ_WRITE, 12'h235, '0, 1);
        add_entry(REQ_READ, 12'h275, '0, 0);
        add_entry(REQ_WRITE, 12'h407, '0, 0);
        add_entry(REQ_WRITE, 12'h417, '0, 0);
        add_entry(REQ_DMA_READ, 12'h406, 4'd2, NO_EXP);
        add_entry(REQ_READ, 12'h407, '0, 1);
        add_entry(REQ_DMA_WRITE, 12'h416, 4'd1, NO_EXP);
        add_entry(REQ_DMA_WRITE, 12'h122, 4'd1, NO_EXP);
        add_entry(REQ_READ, 12'h417, '0, 0);
        add_entry(REQ_READ, 12'h123, '0, 0);
        add_entry(REQ_WRITE, 12'h0a9, '0, 0);
        add_entry(REQ_WRITE, 12'h1b9, '0, 0);
        add_entry(REQ_WRITE, 12'h0ff, '0, 0);
        add_entry(REQ_WRITE, 12'h275, '0, 1);
        add_entry(REQ_FLUSH, '0, '0, NO_EXP);
        add_entry(REQ_READ, 12'h0a9, '0, 0);
        add_entry(REQ_READ, 12'h275, '0, 0);
        add_entry(REQ_READ, 12'h407, '0, 0);
        add_entry(REQ_DMA_READ, 12'h3fe, 4'd3, NO_EXP); // crosses a tag boundary.
        add_entry(REQ_DMA_WRITE, 12'h0a8, 4'd15, NO_EXP);
        add_entry(REQ_READ, 12'h0a9, '0, 0);
        for (int i = 0; i < 24; i++) begin
            add_entry($urandom_range(1, 0) ? REQ_WRITE : REQ_READ,
                      {llc_tag_t'(8'h30 + $urandom_range(5, 0)),
                       llc_set_t'($urandom_range(1, 0))}, '0, NO_EXP);
        end
        add_entry(REQ_FLUSH, '0, '0, NO_EXP);
    endfunction

    initial begin : main_seq
        bit        ok;
        int        errs_before;
        logic      model_hit;
        req_kind_t kind;
        string     verdict;
        void'($urandom(32'h2f7));
        rst        = 1'b0;
        req_valid  = 1'b0;
        req_kind   = REQ_READ;
        req_addr   = '0;
        req_len    = '0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        model_clear();
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        wait_idle(ok); // reset walk.
        timed_out = !ok;
        for (int i = 0; i < tbl_kind.size() && !timed_out; i++) begin
            kind        = tbl_kind[i];
            errs_before = err_count;
            exp_kind.delete();
            exp_addr.delete();
            exp_hit.delete();
            exp_way.delete();
            obs_kind.delete();
            obs_addr.delete();
            obs_hit.delete();
            obs_way.delete();
            model_hit = 1'b0;
            if (kind == REQ_READ || kind == REQ_WRITE) begin
                model_hit = predict_cpu(kind, tbl_addr[i]);
            end else if (kind == REQ_FLUSH) begin
                predict_flush();
            end else begin
                predict_dma(kind, tbl_addr[i], tbl_len[i]);
            end
            if (tbl_exp[i] != NO_EXP && int'(model_hit) != tbl_exp[i]) begin
                $display("reference model predicts hit %0d where the table expects %0d",
                         model_hit, tbl_exp[i]);
                err_count++;
            end
            send_request(kind, tbl_addr[i], tbl_len[i]);
            collect_results(ok);
            if (ok) begin
                compare_results();
                wait_idle(ok);
            end
            timed_out = !ok;
            if (ok && err_count == errs_before) begin
                pass_count++;
                verdict = "ok";
            end else begin
                fail_count++;
                verdict = "FAILED";
            end
            $display("test %0d %s addr %h len %0d: %s",
                     i, kind.name(), tbl_addr[i], tbl_len[i], verdict);
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 pass_count + fail_count, pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* llc_ctrl.f */
design/llc_pkg.sv
design/llc_input_decoder.sv
design/llc_regs.sv
design/llc_tag_store.sv
design/llc_process.sv
design/llc_ctrl_top.sv
testbench/llc_ctrl_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = llc_ctrl_tb
RTL_TOP    = llc_ctrl_top
FILELIST   = llc_ctrl.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
